// File: afu_macros.svh
`ifndef AFU_MACROS_SVH
`define AFU_MACROS_SVH

// Host port widths
`define AFU_ADDR_W 64
`define AFU_DATA_W 64
`define AFU_TAG_W 8

// Work element descriptor fetch
`define AFU_WED_TAG 8'h01
`define AFU_WED_WORDS 4

// Internal reset stretch
`define AFU_RESET_CYCLES 4

// MMIO word offsets
`define AFU_REG_ERRORS 24'd0
`define AFU_REG_WED0 24'd1
`define AFU_REG_WED1 24'd2
`define AFU_REG_WED2 24'd3
`define AFU_REG_WED3 24'd4
`define AFU_REG_SOFT_RESET 24'd5

`endif

// File: cached_afu.sv
`default_nettype none

module cached_afu (
  input  wire                         clock,
  input  wire                         reset,
  input  wire capi_pkg::job_in_t      job_in,
  output capi_pkg::job_out_t          job_out,
  input  wire capi_pkg::command_in_t  command_in,
  output capi_pkg::command_out_t      command_out,
  input  wire capi_pkg::buffer_in_t   buffer_in,
  input  wire capi_pkg::response_t    response,
  input  wire capi_pkg::mmio_in_t     mmio_in,
  output capi_pkg::mmio_out_t         mmio_out
);

  logic                       reset_afu;
  logic                       reset_job;
  logic                       reset_mmio;
  logic                       reset_error;
  logic                       job_error;
  logic                       mmio_error;
  logic                       report_ack;
  logic                       request_taken;
  logic [2:0]                 response_errors;
  capi_pkg::error_sources_t   sources;
  capi_pkg::error_report_t    report;
  capi_pkg::wed_t             wed;
  capi_pkg::command_request_t request;
  capi_pkg::response_t        wed_response;

  assign sources = '{
    job_error:       job_error,
    mmio_error:      mmio_error,
    response_fault:  response_errors[2],
    response_failed: response_errors[1],
    response_paged:  response_errors[0]
  };

  //////////////////////////////////////////////////////////////////////
  // Reset and job
  //////////////////////////////////////////////////////////////////////

  reset_control reset_instant (
    .clock(clock), .reset(reset), .reset_job(reset_job),
    .reset_mmio(reset_mmio), .reset_error(reset_error), .reset_afu(reset_afu)
  );

  job job_instant (
    .clock(clock), .reset_afu(reset_afu), .job_in(job_in), .report(report),
    .wed_valid(wed.valid), .job_out(job_out), .job_error(job_error),
    .reset_job(reset_job)
  );

  //////////////////////////////////////////////////////////////////////
  // Errors and MMIO
  //////////////////////////////////////////////////////////////////////

  error_control error_control_instant (
    .clock(clock), .reset_afu(reset_afu), .enabled(job_out.running),
    .sources(sources), .report_ack(report_ack), .report(report),
    .reset_error(reset_error)
  );

  mmio mmio_instant (
    .clock(clock), .reset_afu(reset_afu), .mmio_in(mmio_in), .report(report),
    .wed(wed), .mmio_out(mmio_out), .mmio_error(mmio_error),
    .report_ack(report_ack), .reset_mmio(reset_mmio)
  );

  //////////////////////////////////////////////////////////////////////
  // WED fetch
  //////////////////////////////////////////////////////////////////////

  wed_control wed_control_instant (
    .clock(clock), .reset_afu(reset_afu), .enabled(job_out.running),
    .wed_address(job_in.address), .buffer_in(buffer_in),
    .wed_response(wed_response), .request_taken(request_taken),
    .request(request), .wed(wed)
  );

  command command_instant (
    .clock(clock), .reset_afu(reset_afu), .request(request),
    .command_in(command_in), .response(response), .request_taken(request_taken),
    .command_out(command_out), .wed_response(wed_response),
    .response_errors(response_errors)
  );

endmodule

`default_nettype wire

// File: cached_afu_tb.sv
`default_nettype none

`include "afu_macros.svh"

module cached_afu_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT = 50;

  logic                   clock;
  logic                   reset;
  capi_pkg::job_in_t      job_in;
  capi_pkg::job_out_t     job_out;
  capi_pkg::command_in_t  command_in;
  capi_pkg::command_out_t command_out;
  capi_pkg::buffer_in_t   buffer_in;
  capi_pkg::response_t    response;
  capi_pkg::mmio_in_t     mmio_in;
  capi_pkg::mmio_out_t    mmio_out;

  int                     errors;
  int                     tests;
  int                     failed_tests;
  int                     errors_at_start;
  logic [15:0]            lfsr = 16'd15421;
  logic [`AFU_DATA_W-1:0] wed_words [4];

  cached_afu u_cached_afu (
    .clock(clock), .reset(reset), .job_in(job_in), .job_out(job_out),
    .command_in(command_in), .command_out(command_out), .buffer_in(buffer_in),
    .response(response), .mmio_in(mmio_in), .mmio_out(mmio_out)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  task automatic random_word(output logic [`AFU_DATA_W-1:0] word);
    word = '0;
    for (int i = 0; i < `AFU_DATA_W; i++) begin
      lfsr = lfsr_next(lfsr);
      word = {word[`AFU_DATA_W-2:0], lfsr[0]};
    end
  endtask

  // Inputs change 1 ns after the edge, outputs read there too
  task automatic step();
    @(posedge clock);
    #1;
  endtask

  function automatic capi_pkg::job_out_t job_status(input logic running, input logic done,
                                                    input logic error);
    return '{running: running, done: done, error: error};
  endfunction

  function automatic capi_pkg::command_out_t wed_read(input logic [`AFU_ADDR_W-1:0] address);
    return '{valid: 1'b1, tag: `AFU_WED_TAG, code: capi_pkg::READ, address: address,
             size: 12'd32};
  endfunction

  // Fatal covers a failed response and a refused job
  function automatic capi_pkg::error_report_t make_report(input logic job_error,
      input logic mmio_error, input logic fault, input logic failed, input logic paged);
    return '{job_error: job_error, mmio_error: mmio_error, response_fault: fault,
             response_failed: failed, response_paged: paged, fatal: failed | job_error};
  endfunction

  // Error register, bit 0 upward in field order
  function automatic logic [`AFU_DATA_W-1:0] pack_report(input capi_pkg::error_report_t r);
    logic [`AFU_DATA_W-1:0] word;
    word    = '0;
    word[0] = r.job_error;
    word[1] = r.mmio_error;
    word[2] = r.response_fault;
    word[3] = r.response_failed;
    word[4] = r.response_paged;
    word[5] = r.fatal;
    return word;
  endfunction

  function automatic capi_pkg::error_report_t unpack_report(input logic [`AFU_DATA_W-1:0] w);
    return '{job_error: w[0], mmio_error: w[1], response_fault: w[2],
             response_failed: w[3], response_paged: w[4], fatal: w[5]};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_job_out(input string name, input capi_pkg::job_out_t got,
                               input capi_pkg::job_out_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Fields other than valid only matter on a valid command
  task automatic check_command(input string name, input capi_pkg::command_out_t got,
                               input capi_pkg::command_out_t exp);
    if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
      errors++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_mmio(input string name, input capi_pkg::mmio_out_t got,
                            input capi_pkg::mmio_out_t exp);
    if (got.ack !== exp.ack || (exp.ack && got !== exp)) begin
      errors++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_report(input string name, input capi_pkg::error_report_t got,
                              input capi_pkg::error_report_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic timed_out(input string what);
    errors++;
    $display("Timeout at %0t while waiting for %s", $time, what);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus and job drivers
  //////////////////////////////////////////////////////////////////////

  task automatic wait_reset_level(input logic level);
    int n;
    n = 0;
    while (u_cached_afu.reset_afu !== level && n < TIMEOUT) begin
      step();
      n++;
    end
    if (n == TIMEOUT) begin
      timed_out("internal reset to change");
    end
  endtask

  task automatic wait_internal_reset();
    wait_reset_level(1'b1);
    wait_reset_level(1'b0);
  endtask

  task automatic wait_for_command(output capi_pkg::command_out_t got);
    int n;
    n = 0;
    while (command_out.valid !== 1'b1 && n < TIMEOUT) begin
      step();
      n++;
    end
    if (n == TIMEOUT) begin
      timed_out("a command");
    end
    got = command_out;
  endtask

  task automatic wait_for_done(output capi_pkg::job_out_t got);
    int n;
    n = 0;
    while (job_out.done !== 1'b1 && n < TIMEOUT) begin
      step();
      n++;
    end
    if (n == TIMEOUT) begin
      timed_out("the job to finish");
    end
    got = job_out;
  endtask

  // One access, then an idle cycle so side effects land
  task automatic mmio_access(input logic write, input logic [23:0] address,
                             input logic [`AFU_DATA_W-1:0] data,
                             output capi_pkg::mmio_out_t got);
    int n;
    mmio_in = '{read: !write, write: write, address: address, data: data};
    step();
    mmio_in = '0;
    n = 0;
    while (mmio_out.ack !== 1'b1 && n < TIMEOUT) begin
      step();
      n++;
    end
    if (n == TIMEOUT) begin
      timed_out("an MMIO acknowledge");
    end else if (n != 0) begin
      errors++;
      $display("MMIO acknowledge came %0d cycles late at %0t", n, $time);
    end
    got = mmio_out;
    step();
    check_mmio("mmio_out.ack", mmio_out, '0);
  endtask

  task automatic check_error_reg(input capi_pkg::error_report_t exp);
    capi_pkg::mmio_out_t got;
    mmio_access(1'b0, `AFU_REG_ERRORS, '0, got);
    check_mmio("mmio_out", got, '{ack: 1'b1, data: pack_report(exp)});
    check_report("report", unpack_report(got.data), exp);
  endtask

  task automatic start_job(input logic [`AFU_ADDR_W-1:0] address);
    job_in = '{valid: 1'b1, cmd: capi_pkg::START, address: address};
    step();
    job_in = '0;
    check_job_out("job_out", job_out, job_status(1'b1, 1'b0, 1'b0));
  endtask

  task automatic send_response(input capi_pkg::response_code_e code);
    response = '{valid: 1'b1, tag: `AFU_WED_TAG, code: code};
    step();
    response = '0;
  endtask

  task automatic begin_test();
    errors_at_start = errors;
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == errors_at_start) begin
      $display("PASS %s", name);
    end else begin
      failed_tests++;
      $display("FAIL %s", name);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_state();
    begin_test();
    check_job_out("job_out", job_out, '0);
    check_command("command_out", command_out, '0);
    check_mmio("mmio_out", mmio_out, '0);
    check_error_reg(make_report(1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
    end_test("reset state");
  endtask

  task automatic wed_fetch();
    capi_pkg::job_out_t     status;
    capi_pkg::mmio_out_t    got;
    logic [`AFU_ADDR_W-1:0] address;
    begin_test();
    address = 64'h0000_1000_2000_3000;
    start_job(address);
    // Command lands two cycles after running
    step();
    step();
    check_command("command_out", command_out, wed_read(address));
    step();
    check_command("command_out", command_out, '0);
    for (int i = 0; i < `AFU_WED_WORDS; i++) begin
      random_word(wed_words[i]);
      buffer_in = '{write_valid: 1'b1, write_tag: `AFU_WED_TAG, write_offset: 2'(i),
                    write_data: wed_words[i]};
      step();
    end
    buffer_in = '0;
    send_response(capi_pkg::DONE);
    wait_for_done(status);
    check_job_out("job_out", status, job_status(1'b0, 1'b1, 1'b0));
    step();
    check_job_out("job_out", job_out, '0);
    for (int i = 0; i < `AFU_WED_WORDS; i++) begin
      mmio_access(1'b0, `AFU_REG_WED0 + 24'(i), '0, got);
      check_mmio("mmio_out", got, '{ack: 1'b1, data: wed_words[i]});
    end
    end_test("job start and WED fetch");
  endtask

  task automatic back_pressure();
    capi_pkg::command_out_t cmd;
    capi_pkg::job_out_t     status;
    logic [`AFU_ADDR_W-1:0] address;
    begin_test();
    address = 64'h0000_0000_0004_0000;
    command_in = '{room: 4'd0};
    start_job(address);
    repeat (10) begin
      step();
      check_command("command_out", command_out, '0);
    end
    command_in = '{room: 4'd2};
    wait_for_command(cmd);
    check_command("command_out", cmd, wed_read(address));
    // Held command goes out once only
    repeat (5) begin
      step();
      check_command("command_out", command_out, '0);
    end
    send_response(capi_pkg::DONE);
    wait_for_done(status);
    check_job_out("job_out", status, job_status(1'b0, 1'b1, 1'b0));
    end_test("back-pressure");
  endtask

  task automatic fault_response();
    capi_pkg::command_out_t cmd;
    capi_pkg::job_out_t     status;
    capi_pkg::mmio_out_t    got;
    begin_test();
    start_job(64'h0000_0000_0008_0040);
    wait_for_command(cmd);
    send_response(capi_pkg::FAULT);
    wait_for_done(status);
    check_job_out("job_out", status, job_status(1'b0, 1'b1, 1'b1));
    check_error_reg(make_report(1'b0, 1'b0, 1'b1, 1'b0, 1'b0));
    mmio_access(1'b1, `AFU_REG_ERRORS, '0, got);
    check_error_reg(make_report(1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
    // WED still there, so no internal reset happened
    mmio_access(1'b0, `AFU_REG_WED0, '0, got);
    check_mmio("mmio_out", got, '{ack: 1'b1, data: wed_words[0]});
    end_test("response fault");
  endtask

  task automatic mmio_errors();
    capi_pkg::mmio_out_t got;
    begin_test();
    mmio_access(1'b0, 24'h20, '0, got);
    check_mmio("mmio_out", got, '{ack: 1'b1, data: '0});
    check_error_reg(make_report(1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
    mmio_access(1'b1, `AFU_REG_SOFT_RESET, '0, got);
    wait_internal_reset();
    check_job_out("job_out", job_out, '0);
    check_error_reg(make_report(1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
    for (int i = 0; i < `AFU_WED_WORDS; i++) begin
      mmio_access(1'b0, `AFU_REG_WED0 + 24'(i), '0, got);
      check_mmio("mmio_out", got, '{ack: 1'b1, data: '0});
    end
    end_test("MMIO errors and soft reset");
  endtask

  task automatic job_reset_fatal();
    capi_pkg::command_out_t cmd;
    capi_pkg::job_out_t     status;
    capi_pkg::mmio_out_t    got;
    begin_test();
    start_job(64'h0000_0000_000C_0000);
    wait_for_command(cmd);
    job_in = '{valid: 1'b1, cmd: capi_pkg::RESET, address: '0};
    step();
    job_in = '0;
    wait_internal_reset();
    check_job_out("job_out", job_out, '0);
    start_job(64'h0000_0000_0010_0080);
    wait_for_command(cmd);
    send_response(capi_pkg::FAILED);
    wait_for_done(status);
    check_job_out("job_out", status, job_status(1'b0, 1'b1, 1'b1));
    check_error_reg(make_report(1'b0, 1'b0, 1'b0, 1'b1, 1'b0));
    // Acknowledging a fatal report restarts the unit
    mmio_access(1'b1, `AFU_REG_ERRORS, '0, got);
    wait_internal_reset();
    repeat (5) begin
      step();
      check_job_out("job_out", job_out, '0);
    end
    check_error_reg(make_report(1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
    end_test("job reset and fatal error");
  endtask

  initial begin
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    reset        = 1'b1;
    job_in       = '0;
    command_in   = '{room: 4'd4};
    buffer_in    = '0;
    response     = '0;
    mmio_in      = '0;
    step();
    step();
    reset = 1'b0;
    wait_internal_reset();

    reset_state();
    wed_fetch();
    back_pressure();
    fault_response();
    mmio_errors();
    job_reset_fatal();

    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: capi_pkg.sv
`default_nettype none

`include "afu_macros.svh"

package capi_pkg;

  typedef enum logic [1:0] {NONE, START, RESET} job_cmd_e;
  typedef enum logic [1:0] {READ, WRITE} command_code_e;
  typedef enum logic [1:0] {DONE, FAULT, FAILED, PAGED} response_code_e;

  // Job control
  typedef struct packed {
    logic                   valid;
    job_cmd_e               cmd;
    logic [`AFU_ADDR_W-1:0] address;
  } job_in_t;

  typedef struct packed {
    logic running;
    logic done;
    logic error;
  } job_out_t;

  // Command and response channels
  typedef struct packed {
    logic [3:0] room;
  } command_in_t;

  typedef struct packed {
    logic                   valid;
    logic [`AFU_TAG_W-1:0]  tag;
    command_code_e          code;
    logic [`AFU_ADDR_W-1:0] address;
    logic [11:0]            size;
  } command_out_t;

  typedef struct packed {
    logic                   write_valid;
    logic [`AFU_TAG_W-1:0]  write_tag;
    logic [1:0]             write_offset;
    logic [`AFU_DATA_W-1:0] write_data;
  } buffer_in_t;

  typedef struct packed {
    logic                  valid;
    logic [`AFU_TAG_W-1:0] tag;
    response_code_e        code;
  } response_t;

  // MMIO
  typedef struct packed {
    logic                   read;
    logic                   write;
    logic [23:0]            address;
    logic [`AFU_DATA_W-1:0] data;
  } mmio_in_t;

  typedef struct packed {
    logic                   ack;
    logic [`AFU_DATA_W-1:0] data;
  } mmio_out_t;

  // Internal
  typedef struct packed {
    logic [`AFU_DATA_W-1:0] word0;
    logic [`AFU_DATA_W-1:0] word1;
    logic [`AFU_DATA_W-1:0] word2;
    logic [`AFU_DATA_W-1:0] word3;
    logic                   valid;
  } wed_t;

  typedef struct packed {
    logic                   valid;
    logic [`AFU_TAG_W-1:0]  tag;
    logic [`AFU_ADDR_W-1:0] address;
  } command_request_t;

  typedef struct packed {
    logic job_error;
    logic mmio_error;
    logic response_fault;
    logic response_failed;
    logic response_paged;
  } error_sources_t;

  typedef struct packed {
    logic job_error;
    logic mmio_error;
    logic response_fault;
    logic response_failed;
    logic response_paged;
    logic fatal;
  } error_report_t;

endpackage

`default_nettype wire

// File: command.sv
`default_nettype none

`include "afu_macros.svh"

module command (
  input  wire                              clock,
  input  wire                              reset_afu,
  input  wire capi_pkg::command_request_t  request,
  input  wire capi_pkg::command_in_t       command_in,
  input  wire capi_pkg::response_t         response,
  output logic                             request_taken,
  output capi_pkg::command_out_t           command_out,
  output capi_pkg::response_t              wed_response,
  output logic [2:0]                       response_errors
);

  logic take;
  logic routed;

  //////////////////////////////////////////////////////////////////////
  // Issue
  //////////////////////////////////////////////////////////////////////

  // Held request goes out on the first cycle with a credit
  assign take          = request.valid && command_in.room != '0;
  assign request_taken = take;

  always_ff @(posedge clock) begin
    if (reset_afu) begin
      command_out.valid <= 1'b0;
    end else begin
      command_out.valid <= take;
    end
    if (take) begin
      command_out.tag     <= request.tag;
      command_out.code    <= capi_pkg::READ;
      command_out.address <= request.address;
      command_out.size    <= 12'(`AFU_WED_WORDS * 8);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Responses
  //////////////////////////////////////////////////////////////////////

  // Only the WED tag is in use, others are dropped
  assign routed = response.valid && response.tag == `AFU_WED_TAG;

  // Error bits: fault, failed, paged from high to low
  always_comb begin
    wed_response       = response;
    wed_response.valid = routed;
    response_errors    = 3'b000;
    if (routed) begin
      case (response.code)
        capi_pkg::FAULT:  response_errors[2] = 1'b1;
        capi_pkg::FAILED: response_errors[1] = 1'b1;
        capi_pkg::PAGED:  response_errors[0] = 1'b1;
        default:          response_errors = 3'b000;
      endcase
    end
  end

  // No command while the host shows no credit
  assert property (@(posedge clock) disable iff (reset_afu)
    command_out.valid |-> command_in.room != '0);

endmodule

`default_nettype wire

// File: error_control.sv
`default_nettype none

module error_control (
  input  wire                           clock,
  input  wire                           reset_afu,
  input  wire                           enabled,
  input  wire capi_pkg::error_sources_t sources,
  input  wire                           report_ack,
  output capi_pkg::error_report_t       report,
  output logic                          reset_error
);

  capi_pkg::error_sources_t sticky;
  capi_pkg::error_sources_t collect_mask;

  // MMIO errors count even between jobs
  always_comb begin
    collect_mask = '1;
    if (!enabled) begin
      collect_mask            = '0;
      collect_mask.mmio_error = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset_afu) begin
      sticky      <= '0;
      reset_error <= 1'b0;
    end else begin
      // Host acknowledges a fatal report, so restart the unit
      reset_error <= report_ack && report.fatal;
      if (report_ack) begin
        sticky <= '0;
      end else begin
        sticky <= sticky | (sources & collect_mask);
      end
    end
  end

  assign report = '{
    job_error:       sticky.job_error,
    mmio_error:      sticky.mmio_error,
    response_fault:  sticky.response_fault,
    response_failed: sticky.response_failed,
    response_paged:  sticky.response_paged,
    fatal:           sticky.response_failed | sticky.job_error
  };

endmodule

`default_nettype wire

// File: job.sv
`default_nettype none

module job (
  input  wire                          clock,
  input  wire                          reset_afu,
  input  wire capi_pkg::job_in_t       job_in,
  input  wire capi_pkg::error_report_t report,
  input  wire                          wed_valid,
  output capi_pkg::job_out_t           job_out,
  output logic                         job_error,
  output logic                         reset_job
);

  typedef enum logic {IDLE, RUNNING} state_e;

  state_e                  state;
  logic                    done_q;
  logic                    error_q;
  logic                    wed_valid_q;
  capi_pkg::error_report_t report_q;
  logic                    start_request;
  logic                    wed_done;
  logic                    new_error;

  assign start_request = job_in.valid && job_in.cmd == capi_pkg::START;
  assign wed_done      = wed_valid && !wed_valid_q;
  // Any report bit that was clear last cycle
  assign new_error     = |(report & ~report_q);

  always_ff @(posedge clock) begin
    if (reset_afu) begin
      state       <= IDLE;
      done_q      <= 1'b0;
      error_q     <= 1'b0;
      job_error   <= 1'b0;
      reset_job   <= 1'b0;
      wed_valid_q <= 1'b0;
      report_q    <= '0;
    end else begin
      done_q      <= 1'b0;
      error_q     <= 1'b0;
      job_error   <= 1'b0;
      reset_job   <= job_in.valid && job_in.cmd == capi_pkg::RESET;
      wed_valid_q <= wed_valid;
      report_q    <= report;
      case (state)
        IDLE: begin
          // A job without a WED address is refused
          if (start_request && job_in.address == '0) begin
            job_error <= 1'b1;
          end else if (start_request) begin
            state <= RUNNING;
          end
        end
        RUNNING: begin
          if (wed_done || new_error) begin
            state   <= IDLE;
            done_q  <= 1'b1;
            error_q <= |report;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign job_out = '{running: state == RUNNING, done: done_q, error: error_q};

  // Job end is a single pulse
  assert property (@(posedge clock) disable iff (reset_afu) job_out.done |=> !job_out.done);

endmodule

`default_nettype wire

// File: mmio.sv
`default_nettype none

`include "afu_macros.svh"

module mmio (
  input  wire                          clock,
  input  wire                          reset_afu,
  input  wire capi_pkg::mmio_in_t      mmio_in,
  input  wire capi_pkg::error_report_t report,
  input  wire capi_pkg::wed_t          wed,
  output capi_pkg::mmio_out_t          mmio_out,
  output logic                         mmio_error,
  output logic                         report_ack,
  output logic                         reset_mmio
);

  logic                   ack;
  logic                   mapped;
  logic [`AFU_DATA_W-1:0] report_word;
  logic [`AFU_DATA_W-1:0] read_word;
  logic [`AFU_DATA_W-1:0] read_data;

  // Report bits low first, in field order
  assign report_word = {{(`AFU_DATA_W - 6){1'b0}}, report.fatal, report.response_paged,
                        report.response_failed, report.response_fault,
                        report.mmio_error, report.job_error};

  // Address decode, unmapped reads give zero
  always_comb begin
    mapped    = 1'b1;
    read_word = '0;
    case (mmio_in.address)
      `AFU_REG_ERRORS:     read_word = report_word;
      `AFU_REG_WED0:       read_word = wed.word0;
      `AFU_REG_WED1:       read_word = wed.word1;
      `AFU_REG_WED2:       read_word = wed.word2;
      `AFU_REG_WED3:       read_word = wed.word3;
      `AFU_REG_SOFT_RESET: read_word = '0;
      default:             mapped = 1'b0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset_afu) begin
      ack        <= 1'b0;
      mmio_error <= 1'b0;
      report_ack <= 1'b0;
      reset_mmio <= 1'b0;
    end else begin
      ack        <= mmio_in.read | mmio_in.write;
      mmio_error <= (mmio_in.read | mmio_in.write) && !mapped;
      report_ack <= mmio_in.write && mmio_in.address == `AFU_REG_ERRORS;
      reset_mmio <= mmio_in.write && mmio_in.address == `AFU_REG_SOFT_RESET;
    end
  end

  always_ff @(posedge clock) begin
    if (mmio_in.read) begin
      read_data <= read_word;
    end
  end

  assign mmio_out = '{ack: ack, data: read_data};

  assert property (@(posedge clock) disable iff (reset_afu) !(mmio_in.read && mmio_in.write));

endmodule

`default_nettype wire

// File: reset_control.sv
`default_nettype none

`include "afu_macros.svh"

module reset_control (
  input  wire  clock,
  input  wire  reset,
  input  wire  reset_job,
  input  wire  reset_mmio,
  input  wire  reset_error,
  output logic reset_afu
);

  localparam int COUNT_W = $clog2(`AFU_RESET_CYCLES + 1);

  logic               any_reset;
  logic [COUNT_W-1:0] count;

  // External pin or any block asking for a reset
  assign any_reset = reset | reset_job | reset_mmio | reset_error;

  // Reload on every request, stretch until the count runs out
  always_ff @(posedge clock) begin
    if (any_reset) begin
      count     <= COUNT_W'(`AFU_RESET_CYCLES);
      reset_afu <= 1'b1;
    end else if (count != '0) begin
      count     <= count - 1'b1;
      reset_afu <= 1'b1;
    end else begin
      reset_afu <= 1'b0;
    end
  end

  // Internal reset follows the pin with no gap
  assert property (@(posedge clock) reset |=> reset_afu);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --assert -j 0 --top-module cached_afu_tb -f src.f -o cached_afu_sim
output=$(./obj_dir/cached_afu_sim)
echo "$output"
if echo "$output" | grep -qx "ALL TESTS PASSED"; then
  exit 0
fi
exit 1

// File: src.f
+incdir+.
capi_pkg.sv
reset_control.sv
job.sv
error_control.sv
mmio.sv
wed_control.sv
command.sv
cached_afu.sv
cached_afu_tb.sv

// File: wed_control.sv
`default_nettype none

`include "afu_macros.svh"

module wed_control (
  input  wire                         clock,
  input  wire                         reset_afu,
  input  wire                         enabled,
  input  wire [`AFU_ADDR_W-1:0]       wed_address,
  input  wire capi_pkg::buffer_in_t   buffer_in,
  input  wire capi_pkg::response_t    wed_response,
  input  wire                         request_taken,
  output capi_pkg::command_request_t  request,
  output capi_pkg::wed_t              wed
);

  logic                   enabled_q;
  logic                   request_valid;
  logic [`AFU_ADDR_W-1:0] address_q;

  always_ff @(posedge clock) begin
    if (reset_afu) begin
      enabled_q     <= 1'b0;
      request_valid <= 1'b0;
      wed           <= '0;
    end else begin
      enabled_q <= enabled;
      // One fetch per job, new job drops the old WED
      if (enabled && !enabled_q) begin
        request_valid <= 1'b1;
        wed.valid     <= 1'b0;
      end else if (request_taken) begin
        request_valid <= 1'b0;
      end
      if (enabled && buffer_in.write_valid && buffer_in.write_tag == `AFU_WED_TAG) begin
        case (buffer_in.write_offset)
          2'd0: wed.word0 <= buffer_in.write_data;
          2'd1: wed.word1 <= buffer_in.write_data;
          2'd2: wed.word2 <= buffer_in.write_data;
          default: wed.word3 <= buffer_in.write_data;
        endcase
      end
      if (enabled && wed_response.valid && wed_response.code == capi_pkg::DONE) begin
        wed.valid <= 1'b1;
      end
    end
  end

  // Track the job address until the job starts
  always_ff @(posedge clock) begin
    if (!enabled) begin
      address_q <= wed_address;
    end
  end

  assign request = '{valid: request_valid, tag: `AFU_WED_TAG, address: address_q};

endmodule

`default_nettype wire
